/* build.f */
+incdir+rtl
rtl/imuldiv_pkg.sv
rtl/imuldiv_ctrl.sv
rtl/imuldiv_sign_unit.sv
rtl/imuldiv_mul_dpath.sv
rtl/imuldiv_div_dpath.sv
rtl/imuldiv_top.sv
tests/imuldiv_tb.sv

/* run.sh */
#!/bin/sh
# compile with Verilator, run, then look for the pass line in the log
rm -f sim.log
verilator --binary --timing --assert --top-module imuldiv_tb -Mdir obj_dir -f build.f \
  || exit 1
./obj_dir/Vimuldiv_tb > sim.log 2>&1
cat sim.log
grep -qx "Verification passed" sim.log && exit 0 || exit 1

/* tests/imuldiv_tb.sv */
// testbench for the iterative multiply/divide unit
// streams directed and random requests, checks each response and the handshake timing
`timescale 1ns/1ns
`include "imuldiv_defines.svh"

module imuldiv_tb;
  import imuldiv_pkg::*;

  // expectation for one accepted request
  typedef struct packed {
    logic [7:0]      id;
    imuldiv_op_e     op;
    imuldiv_result_u exp;
  } check_t;

  localparam int NUM_TESTS = 7;
  localparam int T_RESET   = 0;
  localparam int T_MUL     = 1;
  localparam int T_DIV     = 2;
  localparam int T_DIVU    = 3;
  localparam int T_ZERO    = 4;
  localparam int T_TIMING  = 5;
  localparam int T_HOLD    = 6;

  logic            clk;
  logic            reset;
  logic            req_val;
  imuldiv_req_t    req;
  logic            resp_rdy;
  logic            req_rdy;
  logic            resp_val;
  imuldiv_result_u resp;

  string           test_name [NUM_TESTS] = '{"reset", "mul", "div", "divu", "div_by_zero",
                                             "timing", "back_pressure"};
  int              errors    [NUM_TESTS];
  int              remaining [NUM_TESTS];
  imuldiv_req_t    stim_q [$];
  logic [7:0]      stim_id_q [$];
  check_t          exp_q [$];
  logic [7:0]      cur_id;
  integer          seed = 32'hc132_1c16;
  int              cycle;
  int              limit;
  int              accept_cycle;
  int              resp_count;
  bit              busy;
  bit              resp_seen;
  imuldiv_result_u held;

  imuldiv_top u_dut (
    .clk      (clk),
    .reset    (reset),
    .req_val  (req_val),
    .req      (req),
    .resp_rdy (resp_rdy),
    .req_rdy  (req_rdy),
    .resp_val (resp_val),
    .resp     (resp)
  );

  // 40 ns period
  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // ------------------------------
  // reference model
  // ------------------------------
  function automatic imuldiv_result_u expected_result(imuldiv_op_e op,
                                                      logic [`IMULDIV_XLEN-1:0] a,
                                                      logic [`IMULDIV_XLEN-1:0] b);
    imuldiv_result_u r;
    longint          sa;
    longint          sb;
    sa = longint'($signed(a));
    sb = longint'($signed(b));
    r  = '0;
    if (op == MUL) begin
      r.prod = sa * sb;
    end else if (b == '0) begin
      // zero divisor gives all ones and keeps the dividend
      r.div.quot = '1;
      r.div.rem  = a;
    end else if (op == DIVU) begin
      r.div.quot = a / b;
      r.div.rem  = a % b;
    end else begin
      // 64-bit math so most negative over -1 wraps like the hardware
      r.div.quot = 32'(sa / sb);
      r.div.rem  = 32'(sa % sb);
    end
    return r;
  endfunction

  task automatic add_request(imuldiv_op_e op, logic [31:0] a, logic [31:0] b, int id);
    imuldiv_req_t r;
    r.op = op;
    r.a  = a;
    r.b  = b;
    stim_q.push_back(r);
    stim_id_q.push_back(8'(id));
    remaining[id]++;
  endtask

  task automatic value_error(int id, logic [63:0] exp, logic [63:0] act);
    $display("FAILED %s: expected 0x%0h, actual 0x%0h", test_name[id], exp, act);
    errors[id]++;
  endtask

  task automatic plain_error(int id, string what);
    $display("ERROR in %s: %s", test_name[id], what);
    errors[id]++;
  endtask

  task automatic report_test(int id);
    $display("test %s: %s (%0d errors)", test_name[id],
             (errors[id] == 0) ? "passed" : "failed", errors[id]);
  endtask

  task automatic build_stimulus();
    logic [31:0] a;
    logic [31:0] b;
    // multiply corners, most negative value squared among them
    add_request(MUL, 32'd0, 32'h1234_5678, T_MUL);
    add_request(MUL, 32'd1, 32'hffff_fff9, T_MUL);
    add_request(MUL, 32'hffff_ffff, 32'hffff_ffff, T_MUL);
    add_request(MUL, 32'hffff_ffff, 32'd77, T_MUL);
    add_request(MUL, 32'h8000_0000, 32'h8000_0000, T_MUL);
    add_request(MUL, 32'h7fff_ffff, 32'h8000_0000, T_MUL);
    // every sign combination, then the overflow case
    add_request(DIV, 32'd7, 32'd2, T_DIV);
    add_request(DIV, 32'hffff_fff9, 32'd2, T_DIV);
    add_request(DIV, 32'd7, 32'hffff_fffe, T_DIV);
    add_request(DIV, 32'hffff_fff9, 32'hffff_fffe, T_DIV);
    add_request(DIV, 32'h8000_0000, 32'hffff_ffff, T_DIV);
    add_request(DIVU, 32'hffff_ffff, 32'd3, T_DIVU);
    add_request(DIVU, 32'h8000_0000, 32'hffff_ffff, T_DIVU);
    add_request(DIVU, 32'd5, 32'd7, T_DIVU);
    add_request(DIV, 32'hffff_fffb, 32'd0, T_ZERO);
    add_request(DIV, 32'h8000_0000, 32'd0, T_ZERO);
    add_request(DIVU, 32'hffff_fffb, 32'd0, T_ZERO);
    add_request(DIVU, 32'd0, 32'd0, T_ZERO);
    // random pairs, every other divisor small so quotients vary
    for (int i = 0; i < 40; i++) begin
      a = $random(seed);
      b = $random(seed);
      add_request(MUL, a, b, T_MUL);
      a = $random(seed);
      b = (i % 2 == 0) ? $random(seed) : ($random(seed) % 4096);
      add_request(DIV, a, b, T_DIV);
      a = $random(seed);
      b = (i % 2 == 0) ? $random(seed) : ($random(seed) % 4096);
      add_request(DIVU, a, b, T_DIVU);
    end
  endtask

  task automatic compare_result(check_t c);
    int id;
    id = int'(c.id);
    if (c.op == MUL) begin
      assert (resp.prod == c.exp.prod) else value_error(id, c.exp.prod, resp.prod);
    end else begin
      assert (resp.div.rem == c.exp.div.rem)
        else value_error(id, 64'(c.exp.div.rem), 64'(resp.div.rem));
      assert (resp.div.quot == c.exp.div.quot)
        else value_error(id, 64'(c.exp.div.quot), 64'(resp.div.quot));
    end
    remaining[id]--;
    if (remaining[id] == 0) begin
      report_test(id);
    end
  endtask

  // ------------------------------
  // compare process
  // ------------------------------
  always @(posedge clk) begin : compare
    check_t c;
    cycle = cycle + 1;
    if (cycle > limit) begin
      $display("timeout after %0d cycles, the unit stopped making progress", cycle);
      $display("Verification failed");
      $finish;
    end else if (!reset) begin
      // nothing may be accepted while an operation is in flight
      if (busy) begin
        assert (!req_rdy) else plain_error(T_TIMING, "req_rdy high while busy");
      end
      if (resp_val && !resp_seen) begin
        resp_seen = 1'b1;
        held      = resp;
        assert (cycle - accept_cycle == `IMULDIV_NUM_ITER + 1)
          else value_error(T_TIMING, 64'(`IMULDIV_NUM_ITER + 1), 64'(cycle - accept_cycle));
      end else if (resp_val) begin
        // stalled response must not move
        assert (resp == held) else value_error(T_HOLD, held.prod, resp.prod);
      end
      if (resp_val && resp_rdy) begin
        assert (exp_q.size() > 0) else plain_error(T_HOLD, "response with no request pending");
        if (exp_q.size() > 0) begin
          c = exp_q.pop_front();
          compare_result(c);
        end
        busy       = 1'b0;
        resp_seen  = 1'b0;
        resp_count = resp_count + 1;
      end
      if (req_val && req_rdy) begin
        assert (!busy) else plain_error(T_HOLD, "second request accepted before the response");
        c.id  = cur_id;
        c.op  = req.op;
        c.exp = expected_result(req.op, req.a, req.b);
        exp_q.push_back(c);
        busy         = 1'b1;
        accept_cycle = cycle;
      end
    end
  end

  // response side stalls 0 to 10 cycles before taking each result
  initial begin : resp_stall
    int unsigned stall;
    resp_rdy = 1'b0;
    forever begin
      @(posedge clk);
      if (resp_val) begin
        stall = $unsigned($random(seed)) % 11;
        repeat (stall) @(posedge clk);
        resp_rdy <= 1'b1;
        @(posedge clk);
        resp_rdy <= 1'b0;
      end
    end
  end

  // ------------------------------
  // request driver and report
  // ------------------------------
  initial begin : driver
    int fails;
    reset   = 1'b1;
    req_val = 1'b0;
    req     = '0;
    cur_id  = '0;
    build_stimulus();
    limit = 60 * stim_q.size() + 100;
    repeat (2) @(posedge clk);
    reset <= 1'b0;
    @(posedge clk);
    assert (req_rdy && !resp_val) else plain_error(T_RESET, "handshake wrong after reset");
    report_test(T_RESET);
    // next request waits on the bus while the previous one runs
    foreach (stim_q[i]) begin
      req_val <= 1'b1;
      req     <= stim_q[i];
      cur_id  <= stim_id_q[i];
      do begin
        @(posedge clk);
      end while (!req_rdy);
    end
    req_val <= 1'b0;
    while (resp_count < stim_q.size()) begin
      @(posedge clk);
    end
    report_test(T_TIMING);
    report_test(T_HOLD);
    fails = 0;
    for (int t = 0; t < NUM_TESTS; t++) begin
      if (errors[t] != 0) begin
        fails++;
      end
    end
    $display("tests passed: %0d, failed: %0d", NUM_TESTS - fails, fails);
    if (fails == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

/* rtl/imuldiv_top.sv */
// iterative integer multiply/divide unit
// valid/ready request in, 64-bit result out, one operation at a time
`timescale 1ns/1ns
`include "imuldiv_defines.svh"

module imuldiv_top (
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          req_val,
  input  imuldiv_pkg::imuldiv_req_t      req,
  input  logic                          resp_rdy,
  output logic                          req_rdy,
  output logic                          resp_val,
  output imuldiv_pkg::imuldiv_result_u   resp
);
  import imuldiv_pkg::*;

  imuldiv_ctrl_t              ctrl;
  logic [`IMULDIV_XLEN-1:0]   a_mag;
  logic [`IMULDIV_XLEN-1:0]   b_mag;
  logic [2*`IMULDIV_XLEN-1:0] prod_mag;
  imuldiv_div_res_t           div_mag;

  // ------------------------------
  // sequencing
  // ------------------------------
  imuldiv_ctrl u_ctrl (
    .clk      (clk),
    .reset    (reset),
    .req_val  (req_val),
    .req_op   (req.op),
    .resp_rdy (resp_rdy),
    .req_rdy  (req_rdy),
    .resp_val (resp_val),
    .ctrl     (ctrl)
  );

  // magnitudes in, signed result out
  imuldiv_sign_unit u_sign (
    .clk      (clk),
    .reset    (reset),
    .ctrl     (ctrl),
    .req      (req),
    .prod_mag (prod_mag),
    .div_mag  (div_mag),
    .a_mag    (a_mag),
    .b_mag    (b_mag),
    .result   (resp)
  );

  // both datapaths run every operation, sign unit picks the view
  imuldiv_mul_dpath u_mul (
    .clk      (clk),
    .reset    (reset),
    .ctrl     (ctrl),
    .a_mag    (a_mag),
    .b_mag    (b_mag),
    .prod_mag (prod_mag)
  );

  imuldiv_div_dpath u_div (
    .clk     (clk),
    .reset   (reset),
    .ctrl    (ctrl),
    .a_mag   (a_mag),
    .b_mag   (b_mag),
    .div_mag (div_mag)
  );

endmodule

/* rtl/imuldiv_div_dpath.sv */
// restoring divider over unsigned magnitudes
// one quotient bit per step, dividend bits shift out as quotient shifts in
`timescale 1ns/1ns
`include "imuldiv_defines.svh"

module imuldiv_div_dpath (
  input  logic                          clk,
  input  logic                          reset,
  input  imuldiv_pkg::imuldiv_ctrl_t     ctrl,
  input  logic [`IMULDIV_XLEN-1:0]       a_mag,
  input  logic [`IMULDIV_XLEN-1:0]       b_mag,
  output imuldiv_pkg::imuldiv_div_res_t  div_mag
);

  logic [`IMULDIV_XLEN-1:0] rem_reg;
  logic [`IMULDIV_XLEN-1:0] quo_reg;
  logic [`IMULDIV_XLEN-1:0] divisor;
  logic [`IMULDIV_XLEN:0]   shifted;
  logic [`IMULDIV_XLEN:0]   diff;
  logic                     fits;

  // ------------------------------
  // one restoring step
  // ------------------------------
  // next dividend bit comes from the top of quo_reg
  assign shifted = {rem_reg, quo_reg[`IMULDIV_XLEN-1]};
  assign diff    = shifted - {1'b0, divisor};
  // compare instead of diff sign, shifted may use its top bit
  assign fits    = (shifted >= {1'b0, divisor});

  // divisor held for the whole operation
  always_ff @(posedge clk) begin
    if (ctrl.load) begin
      divisor <= b_mag;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      rem_reg <= '0;
      quo_reg <= '0;
    end else if (ctrl.load) begin
      rem_reg <= '0;
      quo_reg <= a_mag;
    end else if (ctrl.step) begin
      if (fits) begin
        rem_reg <= diff[`IMULDIV_XLEN-1:0];
        quo_reg <= {quo_reg[`IMULDIV_XLEN-2:0], 1'b1};
      end else begin
        // restore, keep the shifted partial remainder
        rem_reg <= shifted[`IMULDIV_XLEN-1:0];
        quo_reg <= {quo_reg[`IMULDIV_XLEN-2:0], 1'b0};
      end
    end
  end

  // zero divisor ends with all ones and the dividend as remainder
  assign div_mag.rem  = rem_reg;
  assign div_mag.quot = quo_reg;

endmodule

/* rtl/imuldiv_mul_dpath.sv */
// shift-and-add multiplier over unsigned magnitudes
// one partial product per step, product valid after the last step
`timescale 1ns/1ns
`include "imuldiv_defines.svh"

module imuldiv_mul_dpath (
  input  logic                        clk,
  input  logic                        reset,
  input  imuldiv_pkg::imuldiv_ctrl_t   ctrl,
  input  logic [`IMULDIV_XLEN-1:0]     a_mag,
  input  logic [`IMULDIV_XLEN-1:0]     b_mag,
  output logic [2*`IMULDIV_XLEN-1:0]   prod_mag
);

  logic [2*`IMULDIV_XLEN-1:0] a_reg;
  logic [`IMULDIV_XLEN-1:0]   b_reg;
  logic [2*`IMULDIV_XLEN-1:0] acc;

  // ------------------------------
  // operand shifters
  // ------------------------------
  always_ff @(posedge clk) begin
    if (ctrl.load) begin
      // a widened so it can walk up into the high half
      a_reg <= {{`IMULDIV_XLEN{1'b0}}, a_mag};
      b_reg <= b_mag;
    end else if (ctrl.step) begin
      a_reg <= a_reg << 1;
      b_reg <= b_reg >> 1;
    end
  end

  // accumulator
  always_ff @(posedge clk) begin
    if (reset) begin
      acc <= '0;
    end else if (ctrl.load) begin
      acc <= '0;
    end else if (ctrl.step && b_reg[0]) begin
      // add the shifted multiplicand for each set multiplier bit
      acc <= acc + a_reg;
    end
  end

  // holds steady once steps stop
  assign prod_mag = acc;

endmodule

/* rtl/imuldiv_sign_unit.sv */
// sign handling around the magnitude datapaths
// strips operand signs at load and restores them on the result
`timescale 1ns/1ns
`include "imuldiv_defines.svh"

module imuldiv_sign_unit (
  input  logic                           clk,
  input  logic                           reset,
  input  imuldiv_pkg::imuldiv_ctrl_t      ctrl,
  input  imuldiv_pkg::imuldiv_req_t       req,
  input  logic [2*`IMULDIV_XLEN-1:0]      prod_mag,
  input  imuldiv_pkg::imuldiv_div_res_t   div_mag,
  output logic [`IMULDIV_XLEN-1:0]        a_mag,
  output logic [`IMULDIV_XLEN-1:0]        b_mag,
  output imuldiv_pkg::imuldiv_result_u    result
);
  import imuldiv_pkg::*;

  logic a_neg;
  logic b_neg;
  logic sign_a_q;
  logic sign_b_q;
  logic b_zero_q;
  logic res_neg;

  // only DIVU treats operands as unsigned
  assign a_neg = (req.op != DIVU) && req.a[`IMULDIV_XLEN-1];
  assign b_neg = (req.op != DIVU) && req.b[`IMULDIV_XLEN-1];

  // two's complement magnitudes go straight to the datapaths
  assign a_mag = a_neg ? (~req.a + 1'b1) : req.a;
  assign b_mag = b_neg ? (~req.b + 1'b1) : req.b;

  // signs and zero divisor captured with the operands
  always_ff @(posedge clk) begin
    if (reset) begin
      sign_a_q <= 1'b0;
      sign_b_q <= 1'b0;
      b_zero_q <= 1'b0;
    end else if (ctrl.load) begin
      sign_a_q <= a_neg;
      sign_b_q <= b_neg;
      b_zero_q <= (req.b == '0);
    end
  end

  assign res_neg = sign_a_q ^ sign_b_q;

  // ------------------------------
  // final sign fix-up
  // ------------------------------
  always_comb begin
    result = '0;
    if (ctrl.is_div) begin
      // divide by zero forces all ones and the divider already left the dividend in rem
      if (b_zero_q) begin
        result.div.quot = '1;
      end else begin
        result.div.quot = res_neg ? (~div_mag.quot + 1'b1) : div_mag.quot;
      end
      // remainder follows the dividend
      result.div.rem = sign_a_q ? (~div_mag.rem + 1'b1) : div_mag.rem;
    end else begin
      result.prod = res_neg ? (~prod_mag + 1'b1) : prod_mag;
    end
  end

  // a finished product magnitude never reaches the sign bit
  a_mul_mag: assert property (@(posedge clk) disable iff (reset)
    (!ctrl.is_div && !ctrl.step) |-> !prod_mag[2*`IMULDIV_XLEN-1]);

endmodule

/* rtl/imuldiv_ctrl.sv */
// FSM for the iterative multiply/divide unit
// runs both handshakes and times the load and step enables
`timescale 1ns/1ns
`include "imuldiv_defines.svh"

module imuldiv_ctrl (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      req_val,
  input  imuldiv_pkg::imuldiv_op_e  req_op,
  input  logic                      resp_rdy,
  output logic                      req_rdy,
  output logic                      resp_val,
  output imuldiv_pkg::imuldiv_ctrl_t ctrl
);
  import imuldiv_pkg::*;

  typedef enum logic [1:0] {
    IDLE = 2'd0,
    CALC = 2'd1,
    DONE = 2'd2
  } state_t;

  state_t     state;
  logic [5:0] count;
  logic       is_div_q;
  logic       accept;
  logic       last_step;

  // handshake on the request side
  assign req_rdy  = (state == IDLE);
  assign resp_val = (state == DONE);
  assign accept   = req_val && req_rdy;

  // count runs 0 .. NUM_ITER-1 while in CALC
  assign last_step = (count == 6'(`IMULDIV_NUM_ITER - 1));

  // ------------------------------
  // state and counter
  // ------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      state    <= IDLE;
      count    <= 6'd0;
      is_div_q <= 1'b0;
    end else begin
      case (state)
        IDLE: begin
          if (accept) begin
            state    <= CALC;
            count    <= 6'd0;
            // op decides how the sign unit reads the result later
            is_div_q <= (req_op != MUL);
          end
        end
        CALC: begin
          count <= count + 6'd1;
          if (last_step) begin
            state <= DONE;
          end
        end
        DONE: begin
          // wait here until the response is taken
          if (resp_rdy) begin
            state <= IDLE;
            count <= 6'd0;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // enables seen by sign unit and both datapaths
  assign ctrl.load   = accept;
  assign ctrl.step   = (state == CALC);
  assign ctrl.is_div = is_div_q;

  // ------------------------------
  // checks
  // ------------------------------
  // a waiting request keeps its op until it is accepted
  a_req_hold: assert property (@(posedge clk) disable iff (reset)
    (req_val && !req_rdy) |=> (req_val && $stable(req_op)));

  a_count_range: assert property (@(posedge clk) disable iff (reset)
    count <= 6'(`IMULDIV_NUM_ITER));

endmodule

/* rtl/imuldiv_pkg.sv */
// types shared by the multiply/divide unit and its testbench
// request, result view and control bundle all live here
`include "imuldiv_defines.svh"

package imuldiv_pkg;

  // ------------------------------
  // operation codes
  // ------------------------------

  // signed mul, signed div, unsigned div
  typedef enum logic [1:0] {
    MUL  = 2'd0,
    DIV  = 2'd1,
    DIVU = 2'd2
  } imuldiv_op_e;

  // one request on the input channel
  typedef struct packed {
    imuldiv_op_e             op;
    logic [`IMULDIV_XLEN-1:0] a;
    logic [`IMULDIV_XLEN-1:0] b;
  } imuldiv_req_t;

  // divide result, remainder sits in the upper half
  typedef struct packed {
    logic [`IMULDIV_XLEN-1:0] rem;
    logic [`IMULDIV_XLEN-1:0] quot;
  } imuldiv_div_res_t;

  // result word, read as a full product or as rem/quot pair
  typedef union packed {
    logic [2*`IMULDIV_XLEN-1:0] prod;
    imuldiv_div_res_t           div;
  } imuldiv_result_u;

  // enables from the control FSM to sign unit and datapaths
  typedef struct packed {
    logic load;
    logic step;
    logic is_div;
  } imuldiv_ctrl_t;

endpackage

/* rtl/imuldiv_defines.svh */
// word width and iteration count shared by the multiply/divide unit
// include wherever a width or the step count is needed
`ifndef IMULDIV_DEFINES_SVH
`define IMULDIV_DEFINES_SVH

// operand width in bits
`define IMULDIV_XLEN 32

// calculation cycles per operation, one result bit each
`define IMULDIV_NUM_ITER 32

`endif
